// ==== compile.f ====
+incdir+include
design/memCtrl_pkg.sv
design/memRequestArbiter.sv
design/byteSequencer.sv
design/memCtrlTop.sv
tb/memCtrl_asserts.sv
tb/tb_memCtrl.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the memory controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_memCtrl -o simv \
    && ./obj_dir/simv 2>&1 | tee sim.log \
    || echo "build or simulation returned an error"

grep -q "^Result: PASSED$" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

// ==== tb/tb_memCtrl.sv ====
`timescale 1ns/100ps
`include "memCtrl_macros.svh"

module tb_memCtrl;

    localparam int TIMEOUT_CYCLES = 4000;

    logic               clk;
    logic               rst;
    logic               i_rdy;
    logic               i_ioBufferFull;
    logic               i_fetchEn;
    logic [`ADDR_W-1:0] i_fetchAddr;
    logic               i_dataEn;
    logic               i_dataWrite;
    logic [`LEN_W-1:0]  i_dataLen;
    logic [`ADDR_W-1:0] i_dataAddr;
    memCtrl_pkg::wordT  i_dataWdata;
    logic [`BYTE_W-1:0] i_memRdata;
    logic [`ADDR_W-1:0] o_memAddr;
    logic               o_memWe;
    logic [`BYTE_W-1:0] o_memWdata;
    logic               o_fetchDone;
    memCtrl_pkg::wordT  o_fetchInst;
    logic               o_dataDone;
    memCtrl_pkg::wordT  o_dataRdata;
    memCtrl_pkg::ownerT o_owner;

    logic [7:0] ram [256];
    logic [7:0] shadow [256];
    logic [7:0] fetchAddrExp;
    logic [7:0] dataAddrExp;
    int         dataLenExp;
    bit         dataWriteExp;
    bit         stallOn;
    int         cycleCount;

    memCtrlTop u_memCtrlTop (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // byte RAM with one cycle read latency
    always @(posedge clk) begin
        if (o_memWe) begin
            ram[o_memAddr[7:0]] <= o_memWdata;
        end
        i_memRdata <= ram[o_memAddr[7:0]];
    end

    // random freeze on either stall input
    always @(posedge clk) begin
        if (stallOn) begin
            i_rdy          <= (($urandom % 4) != 0);
            i_ioBufferFull <= (($urandom % 5) == 0);
        end else begin
            i_rdy          <= 1'b1;
            i_ioBufferFull <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("Result: FAILED");
            $fatal(1, "stopping on first error");
        end
    endtask

    // little-endian word from the shadow memory with zero upper bytes
    function automatic logic [31:0] refWord(input logic [7:0] addr, input int len);
        logic [31:0] w;
        w = '0;
        for (int k = 0; k < len; k++) begin
            w[k*8 +: 8] = shadow[8'(addr + k)];
        end
        return w;
    endfunction

    // every done pulse against the reference
    always @(negedge clk) begin
        if (!rst) begin
            if (o_fetchDone) begin
                checkEq(o_fetchInst, refWord(fetchAddrExp, `INST_BYTES), "fetch word");
            end
            if (o_dataDone && !dataWriteExp) begin
                checkEq(o_dataRdata, refWord(dataAddrExp, dataLenExp), "load data");
            end
            if (!i_rdy || i_ioBufferFull) begin
                checkEq(o_memAddr, 32'd0, "RAM address during stall");
            end
        end
    end

    task automatic waitDone(input bit forFetch, output int cycles);
        cycles = 0;
        @(negedge clk);
        while (!(forFetch ? o_fetchDone : o_dataDone)) begin
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic fetchInstr(input logic [7:0] addr);
        int cycles;
        @(posedge clk);
        fetchAddrExp = addr;
        i_fetchEn   <= 1'b1;
        i_fetchAddr <= `ADDR_W'(addr);
        waitDone(1'b1, cycles);
        if (!stallOn) begin
            checkEq(cycles, 5, "fetch latency");
        end
        @(posedge clk);
        i_fetchEn <= 1'b0;
    endtask

    task automatic accessData(input logic [7:0] addr, input int len, input bit write,
                              input logic [31:0] wdata);
        int cycles;
        @(posedge clk);
        dataAddrExp  = addr;
        dataLenExp   = len;
        dataWriteExp = write;
        i_dataEn    <= 1'b1;
        i_dataWrite <= write;
        i_dataLen   <= `LEN_W'(len);
        i_dataAddr  <= `ADDR_W'(addr);
        i_dataWdata <= wdata;
        waitDone(1'b0, cycles);
        if (!stallOn) begin
            checkEq(cycles, write ? len : len + 1, "data latency");
        end
        @(posedge clk);
        i_dataEn <= 1'b0;
        if (write) begin
            for (int k = 0; k < len; k++) begin
                shadow[8'(addr + k)] = wdata[k*8 +: 8];
            end
            // whole RAM so stray writes show up too
            @(negedge clk);
            for (int a = 0; a < 256; a++) begin
                checkEq(32'(ram[a]), 32'(shadow[a]), "RAM byte after store");
            end
        end
    endtask

    // both clients in the same idle cycle and data goes first
    task automatic simultaneousRequests(input logic [7:0] fAddr, input logic [7:0] dAddr,
                                        input int len);
        int cycles;
        bit dataSeen;
        @(posedge clk);
        fetchAddrExp = fAddr;
        dataAddrExp  = dAddr;
        dataLenExp   = len;
        dataWriteExp = 1'b0;
        i_fetchEn   <= 1'b1;
        i_fetchAddr <= `ADDR_W'(fAddr);
        i_dataEn    <= 1'b1;
        i_dataWrite <= 1'b0;
        i_dataLen   <= `LEN_W'(len);
        i_dataAddr  <= `ADDR_W'(dAddr);
        dataSeen = 1'b0;
        cycles   = 0;
        while (!dataSeen) begin
            @(negedge clk);
            checkEq(32'(o_fetchDone), 32'd0, "fetch done before data done");
            if (cycles > 0) begin
                checkEq(32'(o_owner), 32'(memCtrl_pkg::ownerData), "owner while data served");
            end
            dataSeen = o_dataDone;
            cycles++;
        end
        @(posedge clk);
        i_dataEn <= 1'b0;
        waitDone(1'b1, cycles);
        @(posedge clk);
        i_fetchEn <= 1'b0;
    endtask

    initial begin
        int kind;
        int len;
        logic [7:0] addr;
        void'($urandom(40480));
        for (int i = 0; i < 256; i++) begin
            ram[i]    = 8'($urandom);
            shadow[i] = ram[i];
        end
        cycleCount = 0;
        stallOn = 1'b0;
        dataWriteExp = 1'b0;
        rst = 1'b1;
        i_rdy = 1'b1;
        i_ioBufferFull = 1'b0;
        i_fetchEn = 1'b0;
        i_fetchAddr = '0;
        i_dataEn = 1'b0;
        i_dataWrite = 1'b0;
        i_dataLen = '0;
        i_dataAddr = '0;
        i_dataWdata = '0;
        i_memRdata = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // quiet after reset
        repeat (10) begin
            @(negedge clk);
            checkEq(32'(o_owner), 32'(memCtrl_pkg::ownerNone), "owner when idle");
            checkEq(32'(o_fetchDone | o_dataDone | o_memWe), 32'd0, "activity when idle");
        end

        fetchInstr(8'h10);
        fetchInstr(8'h41);
        for (int s = 0; s < 3; s++) begin
            accessData(8'(8'h20 + 7 * s), 1 << s, 1'b0, '0);
        end
        for (int s = 0; s < 3; s++) begin
            addr = 8'(8'h80 + 9 * s);
            accessData(addr, 1 << s, 1'b1, $urandom);
            accessData(addr, 1 << s, 1'b0, '0);
        end
        simultaneousRequests(8'h30, 8'h60, 4);

        // same traffic under random stalls
        @(negedge clk);
        stallOn = 1'b1;
        repeat (40) begin
            kind = $urandom % 3;
            len  = 1 << ($urandom % 3);
            addr = 8'($urandom);
            if (kind == 0) begin
                fetchInstr(addr);
            end else begin
                accessData(addr, len, kind == 2, $urandom);
            end
        end
        @(negedge clk);
        stallOn = 1'b0;
        repeat (5) @(posedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== tb/memCtrl_asserts.sv ====
`timescale 1ns/100ps

module memCtrl_asserts (
    input logic               clk,
    input logic               rst,
    input logic               i_rdy,
    input logic               i_ioBufferFull,
    input logic               i_finish,
    input logic               i_memWe,
    input logic               i_fetchDone,
    input logic               i_dataDone,
    input memCtrl_pkg::ownerT i_owner
);

    // a finish reaches exactly one client
    assert property (@(posedge clk) disable iff (rst)
        i_finish |-> $onehot({i_fetchDone, i_dataDone}))
        else $error("finish pulse not routed to exactly one client");

    // frozen controller never writes
    assert property (@(posedge clk) disable iff (rst)
        (!i_rdy || i_ioBufferFull) |-> !i_memWe)
        else $error("RAM write enable high during a stall");

    // finish and writes need an owner
    assert property (@(posedge clk) disable iff (rst)
        (i_finish || i_memWe) |-> (i_owner != memCtrl_pkg::ownerNone))
        else $error("finish or RAM write while no client owns the RAM");

endmodule

bind memCtrlTop memCtrl_asserts u_asserts (
    .clk            (clk),
    .rst            (rst),
    .i_rdy          (i_rdy),
    .i_ioBufferFull (i_ioBufferFull),
    .i_finish       (finish),
    .i_memWe        (o_memWe),
    .i_fetchDone    (o_fetchDone),
    .i_dataDone     (o_dataDone),
    .i_owner        (o_owner)
);

// ==== design/memCtrlTop.sv ====
`timescale 1ns/100ps
`include "memCtrl_macros.svh"

module memCtrlTop (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_rdy,
    input  logic               i_ioBufferFull,
    input  logic               i_fetchEn,
    input  logic [`ADDR_W-1:0] i_fetchAddr,
    input  logic               i_dataEn,
    input  logic               i_dataWrite,
    input  logic [`LEN_W-1:0]  i_dataLen,
    input  logic [`ADDR_W-1:0] i_dataAddr,
    input  memCtrl_pkg::wordT  i_dataWdata,
    input  logic [`BYTE_W-1:0] i_memRdata,
    output logic [`ADDR_W-1:0] o_memAddr,
    output logic               o_memWe,
    output logic [`BYTE_W-1:0] o_memWdata,
    output logic               o_fetchDone,
    output memCtrl_pkg::wordT  o_fetchInst,
    output logic               o_dataDone,
    output memCtrl_pkg::wordT  o_dataRdata,
    output memCtrl_pkg::ownerT o_owner
);

    logic                advance;
    logic                start;
    logic                finish;
    memCtrl_pkg::accessT access;
    logic [`LEN_W-1:0]   len;
    logic [`ADDR_W-1:0]  addr;
    memCtrl_pkg::wordT   wdata;
    memCtrl_pkg::wordT   word;

    // frozen on global not-ready or full I/O buffer
    assign advance = i_rdy && !i_ioBufferFull;

    memRequestArbiter u_arbiter (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_advance   (advance),
        .i_fetchEn   (i_fetchEn),
        .i_fetchAddr (i_fetchAddr),
        .i_dataEn    (i_dataEn),
        .i_dataWrite (i_dataWrite),
        .i_dataLen   (i_dataLen),
        .i_dataAddr  (i_dataAddr),
        .i_dataWdata (i_dataWdata),
        .i_finish    (finish),
        .o_owner     (o_owner),
        .o_start     (start),
        .o_access    (access),
        .o_len       (len),
        .o_addr      (addr),
        .o_wdata     (wdata)
    );

    byteSequencer u_sequencer (
        .i_clk      (clk),
        .i_rst      (rst),
        .i_advance  (advance),
        .i_start    (start),
        .i_access   (access),
        .i_len      (len),
        .i_addr     (addr),
        .i_wdata    (wdata),
        .i_memRdata (i_memRdata),
        .o_memAddr  (o_memAddr),
        .o_memWe    (o_memWe),
        .o_memWdata (o_memWdata),
        .o_finish   (finish),
        .o_word     (word)
    );

    // route the finish pulse to whoever owns the RAM
    assign o_fetchDone = finish && (o_owner == memCtrl_pkg::ownerFetch);
    assign o_dataDone  = finish && (o_owner == memCtrl_pkg::ownerData);
    assign o_fetchInst = o_fetchDone ? word : '0;
    assign o_dataRdata = o_dataDone ? word : '0;

endmodule

// ==== design/byteSequencer.sv ====
`timescale 1ns/100ps
`include "memCtrl_macros.svh"

module byteSequencer (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_advance,
    input  logic                i_start,
    input  memCtrl_pkg::accessT i_access,
    input  logic [`LEN_W-1:0]   i_len,
    input  logic [`ADDR_W-1:0]  i_addr,
    input  memCtrl_pkg::wordT   i_wdata,
    input  logic [`BYTE_W-1:0]  i_memRdata,
    output logic [`ADDR_W-1:0]  o_memAddr,
    output logic                o_memWe,
    output logic [`BYTE_W-1:0]  o_memWdata,
    output logic                o_finish,
    output memCtrl_pkg::wordT   o_word
);

    logic              active;
    logic              running;
    logic              isWrite;
    logic              issuing;
    logic              memOn;
    logic [`LEN_W-1:0] issueCnt;
    logic [`LEN_W-1:0] rxCnt;
    logic [1:0]        issueLane;
    logic [1:0]        rxLane;
    logic              rdPend;
    logic              rxLast;
    logic              rxAll;
    logic              wrLast;
    memCtrl_pkg::wordT word;

    assign running   = active | i_start;
    assign isWrite   = (i_access == memCtrl_pkg::accWrite);
    assign issuing   = running && (issueCnt < i_len);
    assign memOn     = i_advance && issuing;
    assign issueLane = issueCnt[1:0];
    assign rxLane    = rxCnt[1:0];

    // output stage: one byte address per advancing cycle
    always_comb begin
        o_memAddr  = '0;
        o_memWe    = 1'b0;
        o_memWdata = '0;
        if (memOn) begin
            o_memAddr = i_addr + `ADDR_W'(`ADDR_STEP * issueCnt);
            if (isWrite) begin
                o_memWe    = 1'b1;
                o_memWdata = i_wdata[issueLane*`BYTE_W +: `BYTE_W];
            end
        end
    end

    // last byte arriving now, or already caught during a stall
    assign rxLast = rdPend && (rxCnt == i_len - `LEN_W'(1));
    assign rxAll  = (rxCnt == i_len);
    assign wrLast = issuing && (issueCnt == i_len - `LEN_W'(1));

    always_comb begin
        o_finish = 1'b0;
        if (i_advance && running) begin
            if (isWrite) begin
                o_finish = wrLast;
            end else begin
                o_finish = rxLast || rxAll;
            end
        end
    end

    // stored bytes plus the one on the bus
    always_comb begin
        o_word = word;
        if (rdPend) begin
            o_word[rxLane*`BYTE_W +: `BYTE_W] = i_memRdata;
        end
    end

    // counters; the input stage follows the RAM, which keeps returning during a stall
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            active   <= 1'b0;
            issueCnt <= '0;
            rxCnt    <= '0;
            rdPend   <= 1'b0;
        end else begin
            rdPend <= memOn && !isWrite;
            if (rdPend) begin
                rxCnt <= rxCnt + `LEN_W'(1);
            end
            if (i_advance) begin
                if (o_finish) begin
                    active   <= 1'b0;
                    issueCnt <= '0;
                    rxCnt    <= '0;
                end else begin
                    if (i_start) begin
                        active <= 1'b1;
                    end
                    if (issuing) begin
                        issueCnt <= issueCnt + `LEN_W'(1);
                    end
                end
            end
        end
    end

    // unused upper lanes stay zero
    always_ff @(posedge i_clk) begin
        if (i_advance && i_start) begin
            word <= '0;
        end else if (rdPend) begin
            word[rxLane*`BYTE_W +: `BYTE_W] <= i_memRdata;
        end
    end

endmodule

// ==== design/memRequestArbiter.sv ====
`timescale 1ns/100ps
`include "memCtrl_macros.svh"

module memRequestArbiter (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_advance,
    input  logic                i_fetchEn,
    input  logic [`ADDR_W-1:0]  i_fetchAddr,
    input  logic                i_dataEn,
    input  logic                i_dataWrite,
    input  logic [`LEN_W-1:0]   i_dataLen,
    input  logic [`ADDR_W-1:0]  i_dataAddr,
    input  memCtrl_pkg::wordT   i_dataWdata,
    input  logic                i_finish,
    output memCtrl_pkg::ownerT  o_owner,
    output logic                o_start,
    output memCtrl_pkg::accessT o_access,
    output logic [`LEN_W-1:0]   o_len,
    output logic [`ADDR_W-1:0]  o_addr,
    output memCtrl_pkg::wordT   o_wdata
);

    memCtrl_pkg::ownerT  owner;
    logic                startQ;
    memCtrl_pkg::accessT accessQ;
    logic [`LEN_W-1:0]   lenQ;
    logic [`ADDR_W-1:0]  addrQ;
    memCtrl_pkg::wordT   wdataQ;
    logic                idle;

    assign idle = (owner == memCtrl_pkg::ownerNone);

    // ownership and start pulse
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            owner  <= memCtrl_pkg::ownerNone;
            startQ <= 1'b0;
        end else if (i_advance) begin
            startQ <= 1'b0;
            if (idle) begin
                // data wins over fetch
                if (i_dataEn) begin
                    owner  <= memCtrl_pkg::ownerData;
                    startQ <= 1'b1;
                end else if (i_fetchEn) begin
                    owner  <= memCtrl_pkg::ownerFetch;
                    startQ <= 1'b1;
                end
            end else if (i_finish) begin
                owner <= memCtrl_pkg::ownerNone;
            end
        end
    end

    // request fields, held for the whole transfer
    always_ff @(posedge i_clk) begin
        if (i_advance && idle) begin
            if (i_dataEn) begin
                accessQ <= i_dataWrite ? memCtrl_pkg::accWrite : memCtrl_pkg::accRead;
                lenQ    <= i_dataLen;
                addrQ   <= i_dataAddr;
                wdataQ  <= i_dataWdata;
            end else if (i_fetchEn) begin
                accessQ <= memCtrl_pkg::accRead;
                lenQ    <= `LEN_W'(`INST_BYTES);
                addrQ   <= i_fetchAddr;
                wdataQ  <= '0;
            end
        end
    end

    assign o_owner  = owner;
    assign o_start  = startQ;
    assign o_access = accessQ;
    assign o_len    = lenQ;
    assign o_addr   = addrQ;
    assign o_wdata  = wdataQ;

endmodule

// ==== design/memCtrl_pkg.sv ====
`include "memCtrl_macros.svh"

package memCtrl_pkg;

    // busy code seen by both clients
    typedef enum logic [1:0] {
        ownerNone  = 2'd0,
        ownerData  = 2'd1,
        ownerFetch = 2'd2
    } ownerT;

    // access kind handed from arbiter to sequencer
    typedef enum logic [1:0] {
        accRead  = 2'd0,
        accWrite = 2'd1
    } accessT;

    typedef logic [`WORD_W-1:0] wordT;

endpackage

// ==== include/memCtrl_macros.svh ====
`ifndef MEMCTRL_MACROS_SVH
`define MEMCTRL_MACROS_SVH

// byte address width
`define ADDR_W 32

// instruction and data word width
`define WORD_W 32

// RAM data port width
`define BYTE_W 8

// holds a byte count of 1 to 4
`define LEN_W 3

// bytes per instruction fetch
`define INST_BYTES 4

// address increment between consecutive bytes
`define ADDR_STEP 1

`endif
